//--- Bender.yml
package:
  name: div_sqrt_unit

sources:
  # RTL in compile order
  - src/divSqrtPkg.sv
  - src/divSqrtStage.sv
  - src/divSqrtIter.sv
  - src/divSqrtCtrl.sv
  - src/divSqrtPost.sv
  - src/divSqrtUnit.sv

  # Simulation only
  - target: simulation
    files:
      - sim/divSqrtUnit_props.sv
      - sim/divSqrtUnitTb.sv

//--- sim/divSqrtUnitTb.sv
// Testbench for the radix-2 SRT divide and square root unit with an integer reference model
`timescale 1ns/1ps

module divSqrtUnitTb;

  localparam int Copies = 1;
  localparam int IterCycles = divSqrtPkg::Digits / Copies;
  // 40 + 40 random, 4 exact, 3 extreme, 1 busy, 2 reset
  localparam int NumOps = 90;
  localparam int CycleLimit = NumOps * (IterCycles + 4) + 100;

  logic clk;
  logic reset;
  logic start;
  divSqrtPkg::divSqrtReqT req;
  logic busy;
  logic done;
  divSqrtPkg::divSqrtResultT result;

  int checkCount = 0;
  int failCount = 0;
  int cycleCount = 0;

  divSqrtUnit #(
    .Copies (Copies)
  ) divSqrtUnit_inst (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycleCount);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Operands scaled by 2^10, quotient scaled by 2^11
  function automatic divSqrtPkg::divSqrtResultT refDivide(input int x, input int d);
    divSqrtPkg::divSqrtResultT r;
    int num;
    num = x << 11;
    r.quotient = divSqrtPkg::rootT'(num / d);
    r.sticky = (num % d) != 0;
    return r;
  endfunction

  // Largest r with r*r <= v, bit by bit
  function automatic int intSqrt(input int v);
    int root;
    int trial;
    root = 0;
    for (int b = 12; b >= 0; b--) begin
      trial = root | (1 << b);
      if (trial * trial <= v) begin
        root = trial;
      end
    end
    return root;
  endfunction

  function automatic divSqrtPkg::divSqrtResultT refSqrt(input int x);
    divSqrtPkg::divSqrtResultT r;
    int v;
    int root;
    v = x << 12;
    root = intSqrt(v);
    r.quotient = divSqrtPkg::rootT'(root);
    r.sticky = (root * root) != v;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input int expected, input int actual);
    checkCount++;
    assert (expected == actual) else begin
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
      failCount++;
    end
  endtask

  // One-cycle start pulse, accepted at the second edge
  task automatic issueRequest(input logic isSqrt, input int x, input int d);
    @(posedge clk);
    start <= 1'b1;
    req.sqrt <= isSqrt;
    req.x <= divSqrtPkg::sigT'(x);
    req.d <= divSqrtPkg::sigT'(d);
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic runAndCheck(input logic isSqrt, input int x, input int d,
                             input divSqrtPkg::divSqrtResultT expected);
    issueRequest(isSqrt, x, d);
    do begin
      @(posedge clk);
    end while (!done);
    checkValue("quotient", expected.quotient, result.quotient);
    checkValue("sticky", expected.sticky, result.sticky);
  endtask

  task automatic reportTest(input int num, input string name, input int failsBefore);
    $display("Test %0d %s: %0d failed checks", num, name, failCount - failsBefore);
  endtask

  initial begin
    divSqrtPkg::divSqrtResultT expected;
    divSqrtPkg::divSqrtResultT got;
    int x;
    int d;
    int doneSeen;
    int failsBefore;
    int propFails;
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    req = '0;
    void'($urandom(14811));
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    failsBefore = failCount;
    for (int i = 0; i < 40; i++) begin
      x = 'h400 | ($urandom & 'h3ff);
      d = 'h400 | ($urandom & 'h3ff);
      runAndCheck(1'b0, x, d, refDivide(x, d));
    end
    reportTest(1, "random division", failsBefore);

    // d is random too, the unit must ignore it
    failsBefore = failCount;
    for (int i = 0; i < 40; i++) begin
      x = 'h400 | ($urandom & 'h3ff);
      d = $urandom & 'h7ff;
      runAndCheck(1'b1, x, d, refSqrt(x));
    end
    reportTest(2, "random square root", failsBefore);

    // Expected values worked out by hand, 1.0 is 0x800 in 1.11
    failsBefore = failCount;
    expected.sticky = 1'b0;
    expected.quotient = 'h800;
    runAndCheck(1'b0, 'h5b7, 'h5b7, expected);
    runAndCheck(1'b1, 'h400, 'h000, expected);
    expected.quotient = 'ha00;
    runAndCheck(1'b1, 'h640, 'h000, expected);
    expected.quotient = 'hc00;
    runAndCheck(1'b0, 'h600, 'h400, expected);
    reportTest(3, "exact cases", failsBefore);

    failsBefore = failCount;
    runAndCheck(1'b0, 'h7ff, 'h400, refDivide('h7ff, 'h400));
    runAndCheck(1'b0, 'h400, 'h7ff, refDivide('h400, 'h7ff));
    runAndCheck(1'b1, 'h7ff, 'h000, refSqrt('h7ff));
    reportTest(4, "extreme operands", failsBefore);

    // Second start lands while busy and must be dropped
    failsBefore = failCount;
    expected = refDivide('h5a3, 'h47c);
    got = '0;
    issueRequest(1'b0, 'h5a3, 'h47c);
    repeat (3) @(posedge clk);
    checkValue("busy", 1, busy);
    start <= 1'b1;
    req.sqrt <= 1'b1;
    req.x <= 'h7ff;
    req.d <= 'h400;
    @(posedge clk);
    start <= 1'b0;
    doneSeen = 0;
    repeat (IterCycles + 8) begin
      @(posedge clk);
      if (done) begin
        doneSeen++;
        got = result;
      end
    end
    checkValue("done count", 1, doneSeen);
    checkValue("quotient", expected.quotient, got.quotient);
    checkValue("sticky", expected.sticky, got.sticky);
    reportTest(5, "start while busy", failsBefore);

    failsBefore = failCount;
    issueRequest(1'b0, 'h6b1, 'h52d);
    repeat (4) @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    reset <= 1'b0;
    repeat (IterCycles + 4) begin
      @(posedge clk);
      checkValue("busy", 0, busy);
      checkValue("done", 0, done);
    end
    runAndCheck(1'b1, 'h5c3, 'h000, refSqrt('h5c3));
    reportTest(6, "reset during an operation", failsBefore);

    propFails = divSqrtUnit_inst.props_inst.failCount;
    $display("Summary: %0d checks, %0d failed, %0d property failures",
             checkCount, failCount, propFails);
    if (failCount == 0 && propFails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sim/divSqrtUnit_props.sv
// Timing properties of the divide and square root unit around start, busy and done
`timescale 1ns/1ps

module divSqrtUnitProps #(
  parameter int Copies = 1
) (
  input logic clk,
  input logic reset,
  input logic start,
  input logic busy,
  input logic done
);

  localparam int IterCycles = divSqrtPkg::Digits / Copies;

  logic accepted;
  logic pending;
  int failCount = 0;

  // Same condition as the sequencer's load
  assign accepted = start && !busy;

  // Set by an accepted start, cleared once its done shows
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (accepted) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////

  donePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done) else begin
    failCount++;
    $error("done stayed high for more than one cycle");
  end

  // Done sits exactly IterCycles+1 edges after the accepting edge
  doneLatency: assert property (@(posedge clk) disable iff (reset)
    accepted |=> !done [*(IterCycles + 1)] ##1 done) else begin
    failCount++;
    $error("done did not follow an accepted start at the expected edge");
  end

  idleAfterReset: assert property (@(posedge clk) reset |=> !busy && !done) else begin
    failCount++;
    $error("busy or done high in the cycle after reset");
  end

  doneNeedsStart: assert property (@(posedge clk) disable iff (reset) done |-> pending) else begin
    failCount++;
    $error("done without an earlier accepted start");
  end

endmodule

bind divSqrtUnit divSqrtUnitProps #(
  .Copies (Copies)
) props_inst (
  .clk   (clk),
  .reset (reset),
  .start (start),
  .busy  (busy),
  .done  (done)
);

//--- src/divSqrtCtrl.sv
// Step sequencer: accepts a start, counts iteration cycles, issues load, step and finish
`timescale 1ns/1ps

module divSqrtCtrl #(
  parameter int Copies = 1
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic load,
  output logic step,
  output logic finish
);

  localparam int IterCycles = divSqrtPkg::Digits / Copies;
  localparam int CntBits = $clog2(IterCycles + 1);

  divSqrtPkg::ctrlStateT state;
  logic [CntBits-1:0] iterCnt;

  // Start is taken only when idle, never while busy
  assign load = start && (state == divSqrtPkg::Idle);
  assign step = (state == divSqrtPkg::Run);
  assign finish = (state == divSqrtPkg::Finish);
  assign busy = (state != divSqrtPkg::Idle);

  ////////////////////////////////////////////////////////////
  // FSM and iteration counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= divSqrtPkg::Idle;
      iterCnt <= '0;
    end else begin
      case (state)
        divSqrtPkg::Idle: begin
          if (load) begin
            state <= divSqrtPkg::Run;
            iterCnt <= '0;
          end
        end
        divSqrtPkg::Run: begin
          // Copies digits per edge
          if (iterCnt == CntBits'(IterCycles - 1)) begin
            state <= divSqrtPkg::Finish;
          end
          iterCnt <= iterCnt + 1'b1;
        end
        divSqrtPkg::Finish: begin
          // Result stage registers at this edge
          state <= divSqrtPkg::Idle;
        end
        default: begin
          state <= divSqrtPkg::Idle;
        end
      endcase
    end
  end

endmodule

//--- src/divSqrtIter.sv
// Iteration datapath with state registers, initialization and a chain of recurrence stages
`timescale 1ns/1ps

module divSqrtIter #(
  parameter int Copies = 1
) (
  input  logic                   clk,
  input  logic                   load,
  input  logic                   step,
  input  divSqrtPkg::divSqrtReqT req,
  output divSqrtPkg::iterStateT  state
);

  localparam int QB = divSqrtPkg::ResBits;
  localparam int FB = divSqrtPkg::FracBits;

  // Registered recurrence state
  divSqrtPkg::residT wsReg, wcReg;
  divSqrtPkg::rootT uReg, umReg;
  divSqrtPkg::maskT cReg;
  divSqrtPkg::sigT dReg;
  logic sqrtReg;

  // Start values
  divSqrtPkg::residT wsInit;
  divSqrtPkg::rootT uInit, umInit;
  divSqrtPkg::maskT cInit;

  // Stage chain whose index 0 is the register output
  divSqrtPkg::residT wsChain [0:Copies];
  divSqrtPkg::residT wcChain [0:Copies];
  divSqrtPkg::rootT uChain [0:Copies];
  divSqrtPkg::rootT umChain [0:Copies];
  divSqrtPkg::maskT cChain [0:Copies];

  ////////////////////////////////////////////////////////////
  // Initialization
  ////////////////////////////////////////////////////////////

  // Divide starts from x/2 and root from x - 1 with the leading one dropped
  assign wsInit = req.sqrt ? {4'b0000, req.x[FB-1:0], 1'b0} : {4'b0000, req.x};

  // Root begins at u = 1.0 and division at zero with um = -1
  assign uInit = req.sqrt ? {1'b1, {(QB-1){1'b0}}} : '0;
  assign umInit = req.sqrt ? '0 : '1;

  // Mask -1 puts the first root digit at 1/2 and -2 puts the first quotient digit at 1
  assign cInit = req.sqrt ? {2'b11, {(QB-1){1'b0}}} : {2'b10, {(QB-1){1'b0}}};

  always_ff @(posedge clk) begin
    if (load) begin
      wsReg <= wsInit;
      wcReg <= '0;
      uReg <= uInit;
      umReg <= umInit;
      cReg <= cInit;
      dReg <= req.d;
      sqrtReg <= req.sqrt;
    end else if (step) begin
      // Feed back the last stage
      wsReg <= wsChain[Copies];
      wcReg <= wcChain[Copies];
      uReg <= uChain[Copies];
      umReg <= umChain[Copies];
      cReg <= cChain[Copies];
    end
  end

  ////////////////////////////////////////////////////////////
  // Chained stages
  ////////////////////////////////////////////////////////////

  assign wsChain[0] = wsReg;
  assign wcChain[0] = wcReg;
  assign uChain[0] = uReg;
  assign umChain[0] = umReg;
  assign cChain[0] = cReg;

  for (genvar i = 0; i < Copies; i++) begin : gStage
    divSqrtStage stage_inst (
      .d      (dReg),
      .sqrt   (sqrtReg),
      .ws     (wsChain[i]),
      .wc     (wcChain[i]),
      .u      (uChain[i]),
      .um     (umChain[i]),
      .c      (cChain[i]),
      .wsNext (wsChain[i+1]),
      .wcNext (wcChain[i+1]),
      .uNext  (uChain[i+1]),
      .umNext (umChain[i+1]),
      .cNext  (cChain[i+1])
    );
  end

  // Postprocessing sees the register outputs
  assign state.ws = wsReg;
  assign state.wc = wcReg;
  assign state.u = uReg;
  assign state.um = umReg;

endmodule

//--- src/divSqrtPkg.sv
// Shared widths, types and FSM states for the radix-2 SRT divide and square root unit
package divSqrtPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand fraction bits, significand is 1.FracBits
  localparam int FracBits = 10;
  localparam int SigBits = FracBits + 1;

  // Result is 1.11, one guard digit beyond the operand
  localparam int ResBits = FracBits + 2;

  // Residual halves are Q4.11
  localparam int ResidBits = ResBits + 3;

  // Root-bit mask is Q2.11
  localparam int MaskBits = ResBits + 1;

  // One recurrence step per result bit
  localparam int Digits = ResBits;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [SigBits-1:0] sigT;
  typedef logic [ResBits-1:0] rootT;
  typedef logic [ResidBits-1:0] residT;
  typedef logic [MaskBits-1:0] maskT;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Request, d is don't-care for square root
  typedef struct packed {
    logic sqrt;
    sigT  x;
    sigT  d;
  } divSqrtReqT;

  // Truncated quotient or root plus inexact flag
  typedef struct packed {
    rootT quotient;
    logic sticky;
  } divSqrtResultT;

  // Carry-save residual and on-the-fly result pair
  typedef struct packed {
    residT ws;
    residT wc;
    rootT  u;
    rootT  um;
  } iterStateT;

  // Sequencer states
  typedef enum logic [1:0] {
    Idle,
    Run,
    Finish
  } ctrlStateT;

endpackage

//--- src/divSqrtPost.sv
// Result stage: resolves the residual, corrects by one unit and registers quotient and sticky
`timescale 1ns/1ps

module divSqrtPost (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      finish,
  input  divSqrtPkg::iterStateT     state,
  output divSqrtPkg::divSqrtResultT result,
  output logic                      done
);

  localparam int RB = divSqrtPkg::ResidBits;

  divSqrtPkg::residT residual;
  divSqrtPkg::rootT corrected;
  logic negative;
  logic sticky;

  ////////////////////////////////////////////////////////////
  // Residual resolution
  ////////////////////////////////////////////////////////////

  // Only carry-propagate adder in the unit
  assign residual = state.ws + state.wc;
  assign negative = residual[RB-1];

  // Negative residual means the last digits overshot, um is one unit lower
  assign corrected = negative ? state.um : state.u;

  // Exact results always end on a zero residual
  assign sticky = |residual;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      done <= 1'b0;
    end else begin
      done <= finish;
      // Held until the next finish
      if (finish) begin
        result.quotient <= corrected;
        result.sticky <= sticky;
      end
    end
  end

endmodule

//--- src/divSqrtStage.sv
// One radix-2 SRT step with digit selection, carry-save residual update and on-the-fly conversion
`timescale 1ns/1ps

module divSqrtStage (
  input  divSqrtPkg::sigT  d,
  input  logic             sqrt,
  input  divSqrtPkg::residT ws,
  input  divSqrtPkg::residT wc,
  input  divSqrtPkg::rootT u,
  input  divSqrtPkg::rootT um,
  input  divSqrtPkg::maskT c,
  output divSqrtPkg::residT wsNext,
  output divSqrtPkg::residT wcNext,
  output divSqrtPkg::rootT uNext,
  output divSqrtPkg::rootT umNext,
  output divSqrtPkg::maskT cNext
);

  localparam int RB = divSqrtPkg::ResidBits;
  localparam int MB = divSqrtPkg::MaskBits;
  localparam int QB = divSqrtPkg::ResBits;

  divSqrtPkg::residT wsShift, wcShift, shiftOr;
  divSqrtPkg::residT dTerm, plusTerm, minusTerm, addend;
  divSqrtPkg::residT minusSum, minusCarry, minusOr;
  divSqrtPkg::residT csaSum, csaCarry;
  divSqrtPkg::maskT cShift, pos;
  divSqrtPkg::rootT posU;
  logic [3:0] est;
  logic digitPos, digitNeg, carryIn, active;
  logic zeroNow, zeroMinus;

  // Doubled residual
  assign wsShift = {ws[RB-2:0], 1'b0};
  assign wcShift = {wc[RB-2:0], 1'b0};

  // Arithmetic shift of the mask
  // The newly set bit is this step's digit weight
  assign cShift = {1'b1, c[MB-1:1]};
  assign pos = cShift & ~c;
  assign posU = pos[QB-1:0];
  // Step holds once the mask is exhausted (last root step)
  assign active = |pos;

  // Divisor aligned to the residual's binary point
  assign dTerm = {{(RB-divSqrtPkg::SigBits-1){1'b0}}, d, 1'b0};

  // Magnitude taken away for digit +1 is d or 2u + p
  assign plusTerm = sqrt ? ({2'b00, u, 1'b0} | {2'b00, pos}) : dTerm;
  // Magnitude added for digit -1 is d or 2um + 3p
  assign minusTerm = sqrt ? ({2'b00, um, 1'b0} | {1'b0, pos, 1'b0} | {2'b00, pos}) : dTerm;

  ////////////////////////////////////////////////////////////
  // Digit selection
  ////////////////////////////////////////////////////////////

  // Four-bit estimate of 2w at integer resolution
  assign est = wsShift[RB-1:RB-4] + wcShift[RB-1:RB-4];

  // Carry-free zero detects use a + b == 0 when a ^ b == (a | b) << 1
  assign shiftOr = wsShift | wcShift;
  assign zeroNow = (wsShift ^ wcShift) == {shiftOr[RB-2:0], 1'b0};

  // Exact zero for digit -1 ends the recurrence
  assign minusSum = wsShift ^ wcShift ^ minusTerm;
  assign minusCarry = {((wsShift[RB-2:0] & wcShift[RB-2:0])
                        | (wsShift[RB-2:0] & minusTerm[RB-2:0])
                        | (wcShift[RB-2:0] & minusTerm[RB-2:0])), 1'b0};
  assign minusOr = minusSum | minusCarry;
  assign zeroMinus = (minusSum ^ minusCarry) == {minusOr[RB-2:0], 1'b0};

  always_comb begin
    digitPos = 1'b0;
    digitNeg = 1'b0;
    if (zeroNow) begin
      // Exact residual keeps digit 0 so it stays zero
      digitPos = 1'b0;
    end else if (zeroMinus) begin
      digitNeg = 1'b1;
    end else if (!est[3]) begin
      digitPos = 1'b1;
    end else if (est != 4'b1111) begin
      digitNeg = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Residual update in carry-save form
  ////////////////////////////////////////////////////////////

  // Digit +1 subtracts with the two's complement increment in the carry LSB
  assign addend = digitPos ? ~plusTerm : (digitNeg ? minusTerm : '0);
  assign carryIn = digitPos;

  assign csaSum = wsShift ^ wcShift ^ addend;
  assign csaCarry = {((wsShift[RB-2:0] & wcShift[RB-2:0]) | (wsShift[RB-2:0] & addend[RB-2:0])
                      | (wcShift[RB-2:0] & addend[RB-2:0])), carryIn};

  assign wsNext = active ? csaSum : ws;
  assign wcNext = active ? csaCarry : wc;

  // On-the-fly conversion keeps um one unit of the current digit below u
  always_comb begin
    uNext = u;
    umNext = um;
    if (active) begin
      if (digitPos) begin
        uNext = u | posU;
        umNext = u;
      end else if (digitNeg) begin
        uNext = um | posU;
        umNext = um;
      end else begin
        umNext = um | posU;
      end
    end
  end

  assign cNext = cShift;

endmodule

//--- src/divSqrtUnit.sv
// Radix-2 SRT divide and square root unit for normalized significands
`timescale 1ns/1ps

module divSqrtUnit #(
  parameter int Copies = 1
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  divSqrtPkg::divSqrtReqT    req,
  output logic                      busy,
  output logic                      done,
  output divSqrtPkg::divSqrtResultT result
);

  // Sequencer controls
  logic load;
  logic step;
  logic finish;

  // Datapath state toward the result stage
  divSqrtPkg::iterStateT state;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  divSqrtCtrl #(
    .Copies (Copies)
  ) ctrl_inst (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .busy   (busy),
    .load   (load),
    .step   (step),
    .finish (finish)
  );

  ////////////////////////////////////////////////////////////
  // Recurrence datapath
  ////////////////////////////////////////////////////////////

  divSqrtIter #(
    .Copies (Copies)
  ) iter_inst (
    .clk   (clk),
    .load  (load),
    .step  (step),
    .req   (req),
    .state (state)
  );

  // Result stage
  divSqrtPost post_inst (
    .clk    (clk),
    .reset  (reset),
    .finish (finish),
    .state  (state),
    .result (result),
    .done   (done)
  );

endmodule

//--- tb.f
src/divSqrtPkg.sv
src/divSqrtStage.sv
src/divSqrtIter.sv
src/divSqrtCtrl.sv
src/divSqrtPost.sv
src/divSqrtUnit.sv
sim/divSqrtUnit_props.sv
sim/divSqrtUnitTb.sv
